// ==== sim.f ====
verilog/mem_gate_pkg.sv
verilog/page_attr_table.sv
verilog/access_check.sv
verilog/tid_gate.sv
verilog/mem_gate_top.sv
tests/mem_gate_asserts.sv
tests/tb_mem_gate.sv

// ==== tests/mem_gate_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

// output protocol checks, bound into the top level
module mem_gate_asserts
  import mem_gate_pkg::*;
(
  input wire       clk,
  input wire       rst,
  input bus_req_t  req_i,        // top's req_o
  input bus_resp_t resp_i        // top's resp_o
);

  // ====================
  // reset
  // ====================
  reset_quiet: assert property (@(posedge clk) rst |=> (!req_i.cyc && !resp_i.ack))
    else $error("strobe active in the cycle after reset");

  // ====================
  // outputs
  // ====================
  // a request either goes downstream or comes back as an error, both two cycles in
  fwd_or_err: assert property (@(posedge clk) disable iff (rst)
      !(req_i.cyc && resp_i.err == ERR_PROTERR))
    else $error("forwarded request and protection error at once");

  err_no_ack: assert property (@(posedge clk) disable iff (rst)
      (resp_i.err == ERR_PROTERR) |-> !resp_i.ack)
    else $error("protection error with ack set");

endmodule

bind mem_gate_top mem_gate_asserts u_asserts (
  .clk        (clk),
  .rst        (rst),
  .req_i      (req_o),
  .resp_i     (resp_o)
);

`default_nettype wire

// ==== tests/tb_mem_gate.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_gate
  import mem_gate_pkg::*;
();

  localparam int MAX_CYCLES   = 2000;          // about four times the whole run
  localparam int WAIT_LIMIT   = 10;            // cycles to wait for an expected strobe
  localparam int QUIET_CYCLES = 5;             // idle window that must stay empty
  localparam int RAND_REQS    = 200;
  localparam int LATENCY      = 2;             // input to output, fixed
  localparam logic [KEY_W-1:0] KEY_BASE = 20'h3c3c0;  // small key pool for random pages

  logic              clk;
  logic              rst;
  bus_req_t          req_i;
  bus_req_t          req_o;
  bus_resp_t         resp_i;
  bus_resp_t         resp_o;
  logic              attr_we_i;
  logic [PAGE_W-1:0] attr_page_i;
  page_attr_t        attr_i;

  page_attr_t        shadow [PAGE_COUNT];      // what the table should hold
  bus_req_t          fwd_q [$];                // requests seen on req_o
  bus_resp_t         resp_q [$];               // responses seen on resp_o
  int                fwd_cyc_q [$];            // cycle of each req_o strobe
  int                resp_cyc_q [$];           // cycle of each resp_o strobe
  int                cycle_cnt = 0;
  logic [TID_W-1:0]  next_tid;

  mem_gate_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .req_o       (req_o),
    .resp_i      (resp_i),
    .resp_o      (resp_o),
    .attr_we_i   (attr_we_i),
    .attr_page_i (attr_page_i),
    .attr_i      (attr_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                     // 8 ns period
  end

  // ====================
  // helpers
  // ====================
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == MAX_CYCLES) stop_run("timeout, the run did not finish in time");
  end

  // outputs change on posedge, so the negedge sees them settled
  always @(negedge clk) begin
    if (!rst) begin
      if (req_o.cyc) begin
        fwd_q.push_back(req_o);
        fwd_cyc_q.push_back(cycle_cnt);
      end
      if (resp_o.ack || resp_o.err == ERR_PROTERR) begin
        resp_q.push_back(resp_o);
        resp_cyc_q.push_back(cycle_cnt);
      end
    end
  end

  function automatic page_attr_t make_attr(logic data_area, logic [KEY_W-1:0] key,
                                           logic [PL_W-1:0] pl);
    page_attr_t a;
    a.data_area = data_area;
    a.key       = key;
    a.pl        = pl;
    return a;
  endfunction

  // passes on a key hit in any slot (or a zero page key) and enough privilege
  function automatic bit predict_pass(page_attr_t a, bus_req_t r);
    bit key_hit;
    bit pl_hit;
    key_hit = (a.key == '0);
    for (int k = 0; k < KEY_COUNT; k++) begin
      if (r.keys[k] == a.key) key_hit = 1'b1;
    end
    if (a.pl == '0) pl_hit = 1'b1;
    else if (!a.data_area) pl_hit = (r.pl == a.pl);   // code page needs the exact level
    else pl_hit = (r.pl >= a.pl);                     // data page needs enough privilege
    if (a.data_area && r.seg == SEG_CODE) pl_hit = 1'b0;  // no fetch from data
    return key_hit && pl_hit;
  endfunction

  function automatic bus_resp_t err_resp_for(bus_req_t r);
    bus_resp_t e;
    e.ack = 1'b0;
    e.err = ERR_PROTERR;
    e.tid = r.tid;
    e.adr = r.padr;
    e.dat = '0;
    return e;
  endfunction

  function automatic bus_resp_t make_resp(logic [TID_W-1:0] tid);
    bus_resp_t d;
    d.ack = 1'b1;
    d.err = ERR_OKAY;
    d.tid = tid;
    d.adr = $urandom;
    d.dat = $urandom;
    return d;
  endfunction

  task automatic load_page(input logic [PAGE_W-1:0] page, input page_attr_t a);
    @(negedge clk);
    attr_we_i   = 1'b1;
    attr_page_i = page;
    attr_i      = a;
    shadow[page] = a;
    @(negedge clk);
    attr_we_i   = 1'b0;
  endtask

  task automatic build_req(input logic [PAGE_W-1:0] page, input logic [PL_W-1:0] pl,
                           input seg_e seg, output bus_req_t r);
    r.cyc  = 1'b1;
    r.we   = 1'($urandom);
    r.seg  = seg;
    r.pl   = pl;
    for (int k = 0; k < KEY_COUNT; k++) r.keys[k] = KEY_W'($urandom);
    r.tid  = next_tid;
    next_tid++;
    r.padr = $urandom;
    r.padr[PAGE_SHIFT +: PAGE_W] = page;      // steer to the wanted page
    r.data = $urandom;
  endtask

  task automatic drive_req(input bus_req_t r, output int sent_cyc);
    @(negedge clk);
    req_i    = r;
    sent_cyc = cycle_cnt;
    @(negedge clk);
    req_i = '0;
  endtask

  task automatic drive_resp(input bus_resp_t d, output int sent_cyc);
    @(negedge clk);
    resp_i   = d;
    sent_cyc = cycle_cnt;
    @(negedge clk);
    resp_i = '0;
  endtask

  // wait for the strobes, then make sure nothing extra shows up
  task automatic expect_results(input int n_fwd, input int n_err);
    int waited;
    waited = 0;
    while (fwd_q.size() < n_fwd || resp_q.size() < n_err) begin
      if (waited == WAIT_LIMIT) stop_run("an expected request or response never appeared");
      @(posedge clk);
      waited++;
    end
    repeat (QUIET_CYCLES) @(posedge clk);
    if (fwd_q.size() != n_fwd) stop_run("an unexpected request appeared on req_o");
    if (resp_q.size() != n_err) stop_run("an unexpected response appeared on resp_o");
  endtask

  task automatic check_latency(input string name, input int seen_cyc, input int sent_cyc);
    if (seen_cyc != sent_cyc + LATENCY)
      stop_run($sformatf("%s came %0d cycles after its input instead of %0d", name,
                         seen_cyc - sent_cyc, LATENCY));
  endtask

  task automatic check_req(input string name, input bus_req_t got, input bus_req_t exp);
    if (got !== exp) stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp);
    if (got !== exp) stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic send_and_check(input bus_req_t r, input bit exp_pass);
    int sent;
    if (predict_pass(shadow[r.padr[PAGE_SHIFT +: PAGE_W]], r) != exp_pass)
      stop_run("directed vector disagrees with the access rules");
    drive_req(r, sent);
    if (exp_pass) begin
      expect_results(1, 0);
      check_latency("req_o", fwd_cyc_q.pop_front(), sent);
      check_req("req_o", fwd_q.pop_front(), r);       // unchanged copy
    end else begin
      expect_results(0, 1);
      check_latency("resp_o", resp_cyc_q.pop_front(), sent);
      check_resp("resp_o", resp_q.pop_front(), err_resp_for(r));
    end
  endtask

  // ====================
  // tests
  // ====================
  task automatic code_page_test();
    bus_req_t r;
    load_page(1, make_attr(1'b0, '0, 8'd3));
    build_req(1, 8'd3, SEG_CODE, r);
    send_and_check(r, 1'b1);
    build_req(1, 8'd2, SEG_CODE, r);
    send_and_check(r, 1'b0);
    build_req(1, 8'd4, SEG_DATA, r);           // higher level is still a mismatch
    send_and_check(r, 1'b0);
  endtask

  task automatic data_page_test();
    bus_req_t r;
    load_page(2, make_attr(1'b1, '0, 8'd4));
    build_req(2, 8'd4, SEG_DATA, r);
    send_and_check(r, 1'b1);
    build_req(2, 8'd7, SEG_STACK, r);
    send_and_check(r, 1'b1);
    build_req(2, 8'd3, SEG_DATA, r);
    send_and_check(r, 1'b0);
    build_req(2, 8'd7, SEG_CODE, r);
    send_and_check(r, 1'b0);
    load_page(3, make_attr(1'b1, '0, 8'd0));   // open data page
    build_req(3, 8'd0, SEG_DATA, r);
    send_and_check(r, 1'b1);
    build_req(3, 8'hff, SEG_STACK, r);
    send_and_check(r, 1'b1);
    build_req(3, 8'd5, SEG_CODE, r);
    send_and_check(r, 1'b0);
    build_req(4, 8'h9a, SEG_CODE, r);          // page 4 still as after reset
    send_and_check(r, 1'b1);
  endtask

  task automatic key_test();
    bus_req_t r;
    logic [KEY_W-1:0] page_key;
    page_key = 20'h5a5a5;
    load_page(5, make_attr(1'b1, page_key, 8'd0));
    for (int slot = 0; slot <= KEY_COUNT; slot++) begin
      build_req(5, 8'd1, SEG_DATA, r);
      for (int k = 0; k < KEY_COUNT; k++) r.keys[k] = page_key ^ KEY_W'(k + 1);
      if (slot < KEY_COUNT) r.keys[slot] = page_key;   // last round has no hit
      send_and_check(r, slot < KEY_COUNT);
    end
    build_req(3, 8'd2, SEG_DATA, r);           // zero key passes any slots
    send_and_check(r, 1'b1);
  endtask

  task automatic response_gate_test();
    bus_req_t  r;
    bus_resp_t d;
    int        sent;
    build_req(1, 8'd3, SEG_CODE, r);
    r.tid = 8'h80;
    send_and_check(r, 1'b1);                   // opens 0x80
    d = make_resp(8'h80);
    drive_resp(d, sent);
    expect_results(0, 1);
    check_latency("resp_o", resp_cyc_q.pop_front(), sent);
    check_resp("resp_o", resp_q.pop_front(), d);
    drive_resp(d, sent);                       // already closed
    expect_results(0, 0);
    drive_resp(make_resp(8'hff), sent);        // never opened
    expect_results(0, 0);
    build_req(1, 8'd3, SEG_CODE, r);
    r.tid = 8'h81;
    send_and_check(r, 1'b1);
    build_req(1, 8'd2, SEG_CODE, r);
    r.tid = 8'h81;
    send_and_check(r, 1'b0);                   // failure closes 0x81 again
    drive_resp(make_resp(8'h81), sent);
    expect_results(0, 0);
  endtask

  task automatic random_test();
    bus_req_t          reqs [$];
    bit                pass_q [$];
    bus_req_t          exp_fwd [$];
    bus_resp_t         exp_err [$];
    int                fwd_sent [$];
    int                err_sent [$];
    bus_req_t          r;
    page_attr_t        a;
    logic [PAGE_W-1:0] page;
    for (int p = 16; p < 32; p++) begin
      a.data_area = 1'($urandom);
      a.key       = ($urandom % 2) ? '0 : KEY_BASE + KEY_W'($urandom % 4);
      a.pl        = PL_W'($urandom % 6);
      load_page(PAGE_W'(p), a);
    end
    for (int i = 0; i < RAND_REQS; i++) begin
      page = PAGE_W'(16 + $urandom % 16);
      build_req(page, PL_W'($urandom % 6), seg_e'($urandom % 3), r);
      r.tid = TID_W'($urandom);
      for (int k = 0; k < KEY_COUNT; k++) begin
        if ($urandom % 3 == 0) r.keys[k] = KEY_BASE + KEY_W'($urandom % 4);
      end
      reqs.push_back(r);
      pass_q.push_back(predict_pass(shadow[page], r));
      if (pass_q[i]) exp_fwd.push_back(r);
      else exp_err.push_back(err_resp_for(r));
    end
    foreach (reqs[i]) begin
      @(negedge clk);
      req_i = reqs[i];                         // one per cycle with no gaps
      if (pass_q[i]) fwd_sent.push_back(cycle_cnt);
      else err_sent.push_back(cycle_cnt);
    end
    @(negedge clk);
    req_i = '0;
    expect_results(exp_fwd.size(), exp_err.size());
    foreach (exp_fwd[i]) begin
      check_latency("req_o", fwd_cyc_q.pop_front(), fwd_sent[i]);
      check_req("req_o", fwd_q.pop_front(), exp_fwd[i]);
    end
    foreach (exp_err[i]) begin
      check_latency("resp_o", resp_cyc_q.pop_front(), err_sent[i]);
      check_resp("resp_o", resp_q.pop_front(), exp_err[i]);
    end
  endtask

  // ====================
  // main
  // ====================
  initial begin
    void'($urandom(23564));
    rst         = 1'b1;
    req_i       = '0;
    resp_i      = '0;
    attr_we_i   = 1'b0;
    attr_page_i = '0;
    attr_i      = '0;
    next_tid    = 8'd1;
    for (int i = 0; i < PAGE_COUNT; i++) shadow[i] = '0;   // table clears on reset
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    code_page_test();
    data_page_test();
    key_test();
    response_gate_test();
    random_test();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/access_check.sv ====
`timescale 1ns/1ns
`default_nettype none

// privilege and key check
// stage 1 waits for the table read, stage 2 registers the verdict
module access_check
  import mem_gate_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  bus_req_t          req_i,            // upstream request
  output logic [PAGE_W-1:0] rd_page_o,        // table read address
  input  page_attr_t        rd_attr_i,        // entry for the delayed request
  output bus_req_t          req_o,            // forwarded request
  output bus_resp_t         loc_resp_o,       // local protection error
  output logic              set_tid_valid_o,  // open a tid on a pass
  output logic [TID_W-1:0]  set_tid_o,
  output logic              clr_tid_valid_o,  // close a tid on a fail
  output logic [TID_W-1:0]  clr_tid_o
);

  bus_req_t req_q;                            // request delayed one stage
  logic     key_ok;
  logic     pl_ok;
  logic     pass;

  // page index straight from the address
  assign rd_page_o = req_i.padr[PAGE_SHIFT +: PAGE_W];

  // ====================
  // stage 1
  // ====================
  always_ff @(posedge clk) begin
    req_q <= req_i;                           // payload follows every cycle
    if (rst) begin
      req_q.cyc <= 1'b0;                      // only the strobe is cleared
    end
  end

  // ====================
  // check
  // ====================
  always_comb begin
    // zero key on the page matches any request
    key_ok = (rd_attr_i.key == '0);
    for (int k = 0; k < KEY_COUNT; k++) begin
      if (req_q.keys[k] == rd_attr_i.key) begin
        key_ok = 1'b1;
      end
    end

    if (!rd_attr_i.data_area) begin
      // code page needs an exact match, unless conforming
      pl_ok = (rd_attr_i.pl == '0) || (rd_attr_i.pl == req_q.pl);
    end else begin
      // data page needs enough privilege, and no code fetch
      pl_ok = ((rd_attr_i.pl == '0) || (rd_attr_i.pl <= req_q.pl))
              && (req_q.seg != SEG_CODE);
    end

    pass = key_ok && pl_ok;
  end

  // gate bitmap updates land on the same edge as req_o
  assign set_tid_valid_o = req_q.cyc && pass;
  assign set_tid_o       = req_q.tid;
  assign clr_tid_valid_o = req_q.cyc && !pass;
  assign clr_tid_o       = req_q.tid;

  // error built in the check cycle and registered by the gate,
  // so it comes out on the same cycle as a forwarded request would
  always_comb begin
    loc_resp_o = '0;
    if (req_q.cyc && !pass) begin
      // error goes back upstream, nothing goes downstream
      loc_resp_o.ack = 1'b0;
      loc_resp_o.err = ERR_PROTERR;
      loc_resp_o.tid = req_q.tid;
      loc_resp_o.adr = req_q.padr;
      loc_resp_o.dat = '0;
    end
  end

  // ====================
  // stage 2
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      req_o <= '0;
    end else begin
      req_o <= '0;                            // strobe lasts one cycle
      if (req_q.cyc && pass) begin
        req_o <= req_q;                       // passed on unchanged
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_gate_pkg.sv ====
`default_nettype none

package mem_gate_pkg;

  // ====================
  // sizes
  // ====================
  localparam int PAGE_W     = 6;             // page index width
  localparam int PAGE_COUNT = 64;            // one attribute entry per page
  localparam int PAGE_SHIFT = 16;            // 64 kB pages
  localparam int KEY_COUNT  = 4;             // keys carried by every request
  localparam int KEY_W      = 20;
  localparam int PL_W       = 8;             // privilege level
  localparam int TID_W      = 8;             // 256 gate bits
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;            // narrowed data path

  // ====================
  // codes
  // ====================
  typedef enum logic [1:0] {
    SEG_CODE  = 2'd0,
    SEG_DATA  = 2'd1,
    SEG_STACK = 2'd2
  } seg_e;

  typedef enum logic {
    ERR_OKAY    = 1'b0,
    ERR_PROTERR = 1'b1                       // privilege or key violation
  } resp_err_e;

  // ====================
  // bus records
  // ====================
  // one table entry, 29 bits
  typedef struct packed {
    logic             data_area;             // 0 = code page
    logic [KEY_W-1:0] key;                   // zero key matches anything
    logic [PL_W-1:0]  pl;                    // zero pl means no privilege needed
  } page_attr_t;

  typedef struct packed {
    logic                           cyc;     // valid strobe
    logic                           we;
    seg_e                           seg;
    logic [PL_W-1:0]                pl;
    logic [KEY_COUNT-1:0][KEY_W-1:0] keys;
    logic [TID_W-1:0]               tid;
    logic [ADDR_W-1:0]              padr;
    logic [DATA_W-1:0]              data;
  } bus_req_t;

  typedef struct packed {
    logic              ack;                  // valid strobe
    resp_err_e         err;
    logic [TID_W-1:0]  tid;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
  } bus_resp_t;

  // a protection error with ack low still counts as a response
  function automatic logic resp_valid(bus_resp_t r);
    return r.ack || (r.err == ERR_PROTERR);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/mem_gate_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// memory access gate
// table -> checker -> gate, requests and errors come out two cycles in
module mem_gate_top
  import mem_gate_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  bus_req_t          req_i,         // upstream request
  output bus_req_t          req_o,         // to downstream
  input  bus_resp_t         resp_i,        // from downstream
  output bus_resp_t         resp_o,        // to upstream
  input  logic              attr_we_i,     // table load port
  input  logic [PAGE_W-1:0] attr_page_i,
  input  page_attr_t        attr_i
);

  logic [PAGE_W-1:0] rd_page;
  page_attr_t        rd_attr;
  bus_resp_t         loc_resp;             // protection errors
  logic              set_tid_valid;
  logic [TID_W-1:0]  set_tid;
  logic              clr_tid_valid;
  logic [TID_W-1:0]  clr_tid;

  // ====================
  // attribute table
  // ====================
  page_attr_table u_table (
    .clk         (clk),
    .rst         (rst),
    .attr_we_i   (attr_we_i),
    .attr_page_i (attr_page_i),
    .attr_i      (attr_i),
    .rd_page_i   (rd_page),
    .rd_attr_o   (rd_attr)
  );

  // ====================
  // request check
  // ====================
  access_check u_check (
    .clk             (clk),
    .rst             (rst),
    .req_i           (req_i),
    .rd_page_o       (rd_page),
    .rd_attr_i       (rd_attr),
    .req_o           (req_o),
    .loc_resp_o      (loc_resp),
    .set_tid_valid_o (set_tid_valid),
    .set_tid_o       (set_tid),
    .clr_tid_valid_o (clr_tid_valid),
    .clr_tid_o       (clr_tid)
  );

  // ====================
  // response gate
  // ====================
  tid_gate u_gate (
    .clk             (clk),
    .rst             (rst),
    .resp_i          (resp_i),
    .loc_resp_i      (loc_resp),
    .set_tid_valid_i (set_tid_valid),
    .set_tid_i       (set_tid),
    .clr_tid_valid_i (clr_tid_valid),
    .clr_tid_i       (clr_tid),
    .resp_o          (resp_o)
  );

endmodule

`default_nettype wire

// ==== verilog/page_attr_table.sv ====
`timescale 1ns/1ns
`default_nettype none

// page attribute memory
// one write port for loading, one registered read port for the checker
module page_attr_table
  import mem_gate_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  logic             attr_we_i,       // load strobe
  input  logic [PAGE_W-1:0] attr_page_i,    // page being loaded
  input  page_attr_t       attr_i,          // new entry
  input  logic [PAGE_W-1:0] rd_page_i,      // page of the incoming request
  output page_attr_t       rd_attr_o        // entry, one cycle later
);

  page_attr_t mem [PAGE_COUNT];             // plain inferred table

  // ====================
  // load port
  // ====================
  // after reset every page is an open code page
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PAGE_COUNT; i++) begin
        mem[i] <= '0;
      end
    end else if (attr_we_i) begin
      mem[attr_page_i] <= attr_i;           // visible to the next request
    end
  end

  // ====================
  // read port
  // ====================
  // read before write on a same-page collision,
  // a load in cycle n is seen from cycle n+1 on
  always_ff @(posedge clk) begin
    rd_attr_o <= mem[rd_page_i];            // lines up with the delayed request
  end

endmodule

`default_nettype wire

// ==== verilog/tid_gate.sv ====
`timescale 1ns/1ns
`default_nettype none

// open-transaction bitmap and response filter
module tid_gate
  import mem_gate_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  bus_resp_t        resp_i,            // downstream response
  input  bus_resp_t        loc_resp_i,        // error from the checker
  input  logic             set_tid_valid_i,
  input  logic [TID_W-1:0] set_tid_i,
  input  logic             clr_tid_valid_i,
  input  logic [TID_W-1:0] clr_tid_i,
  output bus_resp_t        resp_o
);

  logic [2**TID_W-1:0] open_q;                // one bit per tid
  bus_resp_t           resp_q;                // response, stage 1
  logic                fwd;                   // stage 1 response is let through

  // ====================
  // stage 1
  // ====================
  always_ff @(posedge clk) begin
    resp_q <= resp_i;
    if (rst) begin
      resp_q.ack <= 1'b0;
      resp_q.err <= ERR_OKAY;
    end
  end

  // lookup is done late, so a second response with the same tid
  // right behind the first already sees the bit closed
  assign fwd = resp_valid(resp_q) && open_q[resp_q.tid];

  // ====================
  // gate bits
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      open_q <= '0;                           // nothing open
    end else begin
      if (fwd) begin
        open_q[resp_q.tid] <= 1'b0;           // one response per transaction
      end
      if (clr_tid_valid_i) begin
        open_q[clr_tid_i] <= 1'b0;            // failed request
      end
      if (set_tid_valid_i) begin
        open_q[set_tid_i] <= 1'b1;            // last, a reused tid stays open
      end
    end
  end

  // ====================
  // output merge
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_o <= '0;
    end else begin
      resp_o <= '0;                           // single-cycle strobe
      if (fwd) begin
        resp_o <= resp_q;                     // downstream wins a collision
      end else if (resp_valid(loc_resp_i)) begin
        resp_o <= loc_resp_i;
      end
    end
  end

endmodule

`default_nettype wire
